//--- verilog.f
+incdir+include
hw/fetch_pkg.sv
hw/instr_pkg.sv
hw/line_fetch.sv
hw/instruction_queue.sv
hw/length_predecode.sv
hw/prefetch_top.sv
test/wb_imem_model.sv
test/prefetch_tb.sv

//--- Makefile
# Verilator simulation of the instruction prefetch subsystem

VERILATOR ?= verilator
TOP       ?= prefetch_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^ALL TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/prefetch_tb.sv
//********************
// Prefetch testbench
// Directed streams checked against a walk of the memory image
//********************
`default_nettype none
`include "prefetch_macros.svh"

module prefetch_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import fetch_pkg::*;
   import instr_pkg::*;

   // Instructions checked over all tests, 200 ns allowed for each
   localparam int TOTAL_INSTR = 200 + 200 + 122 + 51;

   logic        clk = 1'b0;
   logic        reset;
   redirect_t   redirect;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   instr_t      instr;
   logic        instr_valid;
   logic        instr_ready;
   logic        wait_mode;
   logic [31:0] ref_pc;
   int          value_errors;
   int          other_errors;
   int unsigned seed_value;

   always #4 clk = ~clk;

   prefetch_top prefetch_top_i (
      .clk           (clk),
      .reset_i       (reset),
      .redirect_i    (redirect),
      .wb_req_o      (wb_req),
      .wb_rsp_i      (wb_rsp),
      .instr_o       (instr),
      .instr_valid_o (instr_valid),
      .instr_ready_i (instr_ready)
   );

   wb_imem_model imem_i (
      .clk           (clk),
      .reset_i       (reset),
      .random_wait_i (wait_mode),
      .wb_req_i      (wb_req),
      .wb_rsp_o      (wb_rsp)
   );

   function automatic logic [7:0] mem_byte(input logic [31:0] addr);
      return imem_i.mem[addr[11:0]];
   endfunction

   // Length from the first byte, halt is one byte, unused bytes zero
   function automatic instr_t expected_instr(input logic [31:0] pc);
      instr_t     e;
      logic [7:0] op;
      op     = mem_byte(pc);
      e.halt = (op == `PF_HALT_OP);
      e.len  = e.halt ? 4'd1 : {1'b0, op[2:0]} + 4'd1;
      for (int i = 0; i < 8; i++) begin
         e.bytes[i] = (i < e.len) ? mem_byte(pc + 32'(i)) : 8'h00;
      end
      return e;
   endfunction

   task automatic check_instr(input string name, input instr_t exp, input instr_t act);
      if (act !== exp) begin
         $display("Fail %s expected %h got %h (pc %h)", name, exp, act, ref_pc);
         value_errors++;
      end
   endtask

   // Address is undefined while idle
   // Byte selects only count inside a cycle
   task automatic check_bus(input string name, input wb_req_t exp, input wb_req_t act);
      if (act.cyc !== exp.cyc || act.stb !== exp.stb || act.we !== exp.we ||
          (exp.cyc && act.sel !== exp.sel)) begin
         $display("Fail %s cyc/stb/we/sel expected %h/%h/%h/%h got %h/%h/%h/%h",
                  name, exp.cyc, exp.stb, exp.we, exp.sel,
                  act.cyc, act.stb, act.we, act.sel);
         value_errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s expected %h got %h", name, exp, act);
         value_errors++;
      end
   endtask

   // One-cycle pulse, starts on the current falling edge
   task automatic send_redirect(input logic [31:0] addr);
      redirect.valid = 1'b1;
      redirect.addr  = addr;
      ref_pc         = addr;
      @(negedge clk);
      redirect       = '0;
   endtask

   // Count transfers, sample 2 ns after the drive edge
   task automatic run_stream(input int count, input bit rand_ready, output instr_t last);
      instr_t exp;
      instr_t held;
      logic   stalled;
      int     n;
      n       = 0;
      stalled = 1'b0;
      while (n < count) begin
         @(negedge clk);
         instr_ready = rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;
         #2;
         if (instr_valid) begin
            // Stalled instruction must not move
            if (stalled) begin
               check_instr("instr_o held", held, instr);
            end
            if (instr_ready) begin
               exp = expected_instr(ref_pc);
               check_instr("instr_o", exp, instr);
               last    = instr;
               ref_pc  = ref_pc + 32'(exp.len);
               stalled = 1'b0;
               n++;
            end else begin
               held    = instr;
               stalled = 1'b1;
            end
         end else begin
            // A waiting instruction may not be withdrawn
            if (stalled) begin
               check_flag("instr_valid_o held", 1'b1, instr_valid);
            end
            stalled = 1'b0;
         end
      end
      @(negedge clk);
      instr_ready = 1'b0;
   endtask

   // Stops on the falling edge of a cycle open on the given line, before its ack
   task automatic wait_bus_open(input logic [31:0] addr);
      wb_req_t req;
      bit      found;
      req     = '0;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      req.sel = '1;
      req.adr = {addr[31:4], 4'h0};
      found   = 1'b0;
      for (int c = 0; c < 40 && !found; c++) begin
         @(negedge clk);
         found = wb_req.cyc && !wb_rsp.ack && (wb_req.adr === req.adr);
      end
      if (found) begin
         check_bus("wb_req_o", req, wb_req);
      end else begin
         $display("No bus request to the redirect line within 40 cycles");
         other_errors++;
      end
   endtask

   task automatic test_idle_after_reset();
      wb_req_t idle;
      idle = '0;
      repeat (20) begin
         @(negedge clk);
         #2;
         check_bus("wb_req_o", idle, wb_req);
         check_flag("instr_valid_o", 1'b0, instr_valid);
      end
   endtask

   task automatic test_stream_no_wait();
      instr_t last;
      wait_mode = 1'b0;
      @(negedge clk);
      send_redirect(32'h0);
      run_stream(200, 1'b0, last);
   endtask

   task automatic test_stream_backpressure();
      instr_t last;
      wait_mode = 1'b1;
      @(negedge clk);
      send_redirect(32'h100);
      run_stream(200, 1'b1, last);
   endtask

   // Mid-stream jump, then a jump while the old line is still on the bus
   task automatic test_unaligned_redirect();
      instr_t last;
      wait_mode = 1'b1;
      @(negedge clk);
      send_redirect(32'h40);
      run_stream(20, 1'b1, last);
      send_redirect(32'h2A7);
      run_stream(51, 1'b1, last);
      send_redirect(32'h500);
      wait_bus_open(32'h500);
      send_redirect(32'h2A7);
      run_stream(51, 1'b1, last);
   endtask

   task automatic test_halt_and_resume();
      instr_t      e;
      instr_t      last;
      instr_t      halt_exp;
      logic [31:0] pc;
      wait_mode = 1'b1;
      // Halt lands on the 31st instruction from 0x800
      pc = 32'h800;
      repeat (30) begin
         e  = expected_instr(pc);
         pc = pc + 32'(e.len);
      end
      imem_i.mem[pc[11:0]] = `PF_HALT_OP;
      halt_exp          = '0;
      halt_exp.bytes[0] = `PF_HALT_OP;
      halt_exp.len      = 4'd1;
      halt_exp.halt     = 1'b1;
      @(negedge clk);
      send_redirect(32'h800);
      run_stream(31, 1'b0, last);
      check_instr("instr_o halt", halt_exp, last);
      repeat (100) begin
         @(negedge clk);
         instr_ready = 1'b1;
         #2;
         check_flag("instr_valid_o halted", 1'b0, instr_valid);
      end
      @(negedge clk);
      instr_ready = 1'b0;
      send_redirect(pc + 32'd1);
      run_stream(20, 1'b0, last);
   endtask

   initial begin
      #(TOTAL_INSTR * 200);
      $display("Watchdog expired before the tests finished");
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial begin
      reset        = 1'b1;
      redirect     = '0;
      instr_ready  = 1'b0;
      wait_mode    = 1'b0;
      ref_pc       = '0;
      value_errors = 0;
      other_errors = 0;
      seed_value   = $urandom(22659);
      imem_i.fill_memory();
      repeat (16) @(negedge clk);
      reset = 1'b0;
      test_idle_after_reset();
      test_stream_no_wait();
      test_stream_backpressure();
      test_unaligned_redirect();
      test_halt_and_resume();
      $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- test/wb_imem_model.sv
//********************
// Wishbone memory model
// 4 KB line-wide read slave with optional random wait states
//********************
`default_nettype none
`include "prefetch_macros.svh"

module wb_imem_model (
   input  wire logic               clk,
   input  wire logic               reset_i,
   input  wire logic               random_wait_i,
   input  wire fetch_pkg::wb_req_t wb_req_i,
   output fetch_pkg::wb_rsp_t      wb_rsp_o
);
   timeunit 1ns;
   timeprecision 100ps;

   import fetch_pkg::*;

   localparam int MEM_BYTES = 4096;

   logic [7:0]  mem [MEM_BYTES];
   logic        open_q;
   int unsigned wait_q;

   // Random contents, halt opcode kept out so tests plant it where wanted
   task automatic fill_memory();
      logic [7:0] b;
      for (int a = 0; a < MEM_BYTES; a++) begin
         b = 8'($urandom());
         mem[a] = (b == `PF_HALT_OP) ? 8'h00 : b;
      end
   endtask

   // Whole aligned line, address wraps inside 4 KB
   function automatic line_t read_line(input logic [31:0] adr);
      line_t l;
      for (int i = 0; i < `PF_LINE_BYTES; i++) begin
         l.bytes[i] = mem[{adr[11:4], 4'(i)}];
      end
      return l;
   endfunction

   always @(posedge clk) begin : slave
      int unsigned waits;
      if (reset_i) begin
         open_q       <= 1'b0;
         wait_q       <= 0;
         wb_rsp_o.ack <= 1'b0;
      end else if (wb_rsp_o.ack) begin
         // Single-cycle ack, master drops cyc next
         wb_rsp_o.ack <= 1'b0;
         open_q       <= 1'b0;
      end else if (wb_req_i.cyc && wb_req_i.stb) begin
         // Wait count drawn once per transaction
         waits = open_q ? wait_q : (random_wait_i ? $urandom_range(3, 0) : 0);
         if (waits == 0) begin
            wb_rsp_o.ack <= 1'b1;
            wb_rsp_o.dat <= read_line(wb_req_i.adr);
         end else begin
            wait_q <= waits - 1;
         end
         open_q <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- hw/prefetch_top.sv
//********************
// Prefetch top
// Fetcher, queue and predecoder wired together
//********************
`default_nettype none

module prefetch_top (
   input  wire logic                 clk,
   input  wire logic                 reset_i,
   input  wire instr_pkg::redirect_t redirect_i,
   output fetch_pkg::wb_req_t        wb_req_o,
   input  wire fetch_pkg::wb_rsp_t   wb_rsp_i,
   output instr_pkg::instr_t         instr_o,
   output logic                      instr_valid_o,
   input  wire logic                 instr_ready_i
);

   import fetch_pkg::*;
   import instr_pkg::*;

   // Fetcher to queue
   logic              line_push;
   line_t             line;
   logic              free;
   // Queue and predecoder
   window_t           window;
   logic signed [6:0] valid_bytes;
   logic              consume;
   logic [3:0]        bytes_read;

   line_fetch line_fetch_i (
      .clk         (clk),
      .reset_i     (reset_i),
      .redirect_i  (redirect_i),
      .free_i      (free),
      .wb_req_o    (wb_req_o),
      .wb_rsp_i    (wb_rsp_i),
      .line_push_o (line_push),
      .line_o      (line)
   );

   instruction_queue instruction_queue_i (
      .clk           (clk),
      .reset_i       (reset_i),
      .redirect_i    (redirect_i),
      .line_push_i   (line_push),
      .line_i        (line),
      .free_o        (free),
      .consume_i     (consume),
      .bytes_read_i  (bytes_read),
      .window_o      (window),
      .valid_bytes_o (valid_bytes)
   );

   length_predecode length_predecode_i (
      .clk           (clk),
      .reset_i       (reset_i),
      .redirect_i    (redirect_i),
      .window_i      (window),
      .valid_bytes_i (valid_bytes),
      .consume_o     (consume),
      .bytes_read_o  (bytes_read),
      .instr_o       (instr_o),
      .instr_valid_o (instr_valid_o),
      .instr_ready_i (instr_ready_i)
   );

endmodule

`default_nettype wire

//--- hw/length_predecode.sv
//********************
// Length predecoder
// Sizes the instruction at the head, detects halt, drives issue
//********************
`default_nettype none
`include "prefetch_macros.svh"

module length_predecode (
   input  wire logic                 clk,
   input  wire logic                 reset_i,
   input  wire instr_pkg::redirect_t redirect_i,
   input  wire instr_pkg::window_t   window_i,
   input  wire logic signed [6:0]    valid_bytes_i,
   output logic                      consume_o,
   output logic [3:0]                bytes_read_o,
   output instr_pkg::instr_t         instr_o,
   output logic                      instr_valid_o,
   input  wire logic                 instr_ready_i
);

   logic [7:0] op;
   logic [3:0] len;
   logic       is_halt;
   logic       enough;
   logic       fire;
   logic       halted_q;

   // First byte decides the length
   assign op      = window_i.bytes[0];
   assign is_halt = (op == `PF_HALT_OP);
   assign len     = is_halt ? 4'd1 : 4'(op & `PF_LEN_MASK) + 4'd1;

   // Count can be negative right after an unaligned redirect
   assign enough = (valid_bytes_i > 7'sd0) && (valid_bytes_i >= $signed(7'(len)));

   // No issue in a redirect cycle, the queue is flushing
   assign instr_valid_o = enough & ~halted_q & ~redirect_i.valid;
   assign fire          = instr_valid_o & instr_ready_i;

   assign consume_o    = fire;
   assign bytes_read_o = len;

   // Bytes past the length zeroed so a stalled instruction stays steady
   always_comb begin
      for (int i = 0; i < 8; i++) begin
         instr_o.bytes[i] = (i < len) ? window_i.bytes[i] : 8'h00;
      end
      instr_o.len  = len;
      instr_o.halt = is_halt;
   end

   // Halt sticks until the next redirect
   always_ff @(posedge clk) begin
      if (reset_i) begin
         halted_q <= 1'b0;
      end else if (redirect_i.valid) begin
         halted_q <= 1'b0;
      end else if (fire && is_halt) begin
         halted_q <= 1'b1;
      end
   end

   // Queue keeps the window still while an instruction waits
   a_instr_hold : assert property (@(posedge clk) disable iff (reset_i)
      instr_valid_o && !instr_ready_i |=>
         redirect_i.valid || (instr_valid_o && $stable(instr_o)));

endmodule

`default_nettype wire

//--- hw/instruction_queue.sv
//********************
// Instruction queue
// Four line entries, byte head pointer, signed valid-byte count
// and a 32-byte window shifted to the head
//********************
`default_nettype none
`include "prefetch_macros.svh"

module instruction_queue (
   input  wire logic                 clk,
   input  wire logic                 reset_i,
   input  wire instr_pkg::redirect_t redirect_i,
   input  wire logic                 line_push_i,
   input  wire fetch_pkg::line_t     line_i,
   output logic                      free_o,
   input  wire logic                 consume_i,
   input  wire logic [3:0]           bytes_read_i,
   output instr_pkg::window_t        window_o,
   output logic signed [6:0]         valid_bytes_o
);

   import fetch_pkg::*;

   localparam int IDX_W  = $clog2(`PF_ENTRIES);
   localparam int OFF_W  = $clog2(`PF_LINE_BYTES);
   localparam int HEAD_W = IDX_W + OFF_W;
   // One line worth of count
   localparam logic signed [6:0] VB_LINE  = 7'(`PF_LINE_BYTES);
   // Highest count that still takes a full line without overflow
   localparam logic signed [6:0] VB_LIMIT = 7'(64 - `PF_LINE_BYTES);

   line_t                         line_q [`PF_ENTRIES];
   logic [`PF_ENTRIES-1:0]        valid_q;
   logic [IDX_W-1:0]              tail_q;
   logic [HEAD_W-1:0]             head_q;
   logic [HEAD_W-1:0]             head_nxt;
   logic [IDX_W-1:0]              head_ent;
   logic [IDX_W-1:0]              next_ent;
   logic                          leave_line;
   logic signed [6:0]             vbytes_q;
   logic signed [6:0]             vbytes_nxt;
   logic [`PF_WINDOW_BYTES*8-1:0] pair;

   // Head splits into entry index and byte offset
   assign head_ent = head_q[HEAD_W-1:OFF_W];
   assign next_ent = head_ent + 1'b1;

   // Head wraps over all four lines
   assign head_nxt = head_q + HEAD_W'(bytes_read_i);

   // At most 8 bytes read, so at most one line boundary crossed
   assign leave_line = consume_i & (head_nxt[HEAD_W-1:OFF_W] != head_ent);

   // Count update, push and consume may land together
   always_comb begin
      vbytes_nxt = vbytes_q;
      if (line_push_i) begin
         vbytes_nxt = vbytes_nxt + VB_LINE;
      end
      if (consume_i) begin
         vbytes_nxt = vbytes_nxt - $signed(7'(bytes_read_i));
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         valid_q  <= '0;
         tail_q   <= '0;
         head_q   <= '0;
         vbytes_q <= '0;
      end else if (redirect_i.valid) begin
         // Flush, head lands on the target byte inside entry 0
         valid_q  <= '0;
         tail_q   <= '0;
         head_q   <= HEAD_W'(redirect_i.addr[OFF_W-1:0]);
         // Leading bytes of the first line are skipped
         vbytes_q <= -$signed(7'(redirect_i.addr[OFF_W-1:0]));
      end else begin
         if (line_push_i) begin
            valid_q[tail_q] <= 1'b1;
            tail_q          <= tail_q + 1'b1;
         end
         // Entry freed once the head moves past it
         if (leave_line) begin
            valid_q[head_ent] <= 1'b0;
         end
         if (consume_i) begin
            head_q <= head_nxt;
         end
         vbytes_q <= vbytes_nxt;
      end
   end

   // Line storage
   always_ff @(posedge clk) begin
      if (line_push_i) begin
         line_q[tail_q] <= line_i;
      end
   end

   // Head line below the next one, then shift by the byte offset
   assign pair     = {line_q[next_ent], line_q[head_ent]};
   assign window_o = pair >> {head_q[OFF_W-1:0], 3'b000};

   // Free needs an empty entry, no fill landing now and count headroom
   assign free_o        = ~(&valid_q) & ~line_push_i & (vbytes_q < VB_LIMIT);
   assign valid_bytes_o = vbytes_q;

   // Fetcher only starts on free, so its push must find room
   a_push_room : assert property (@(posedge clk) disable iff (reset_i)
      line_push_i |-> !(&valid_q));

   // Predecoder never reads past the filled bytes
   a_read_valid : assert property (@(posedge clk) disable iff (reset_i)
      consume_i |-> ($signed(7'(bytes_read_i)) <= vbytes_q));

endmodule

`default_nettype wire

//--- hw/line_fetch.sv
//********************
// Line fetcher
// Wishbone classic master reading aligned 16-byte lines,
// stale lines after a redirect are dropped
//********************
`default_nettype none
`include "prefetch_macros.svh"

module line_fetch (
   input  wire logic                 clk,
   input  wire logic                 reset_i,
   input  wire instr_pkg::redirect_t redirect_i,
   input  wire logic                 free_i,
   output fetch_pkg::wb_req_t        wb_req_o,
   input  wire fetch_pkg::wb_rsp_t   wb_rsp_i,
   output logic                      line_push_o,
   output fetch_pkg::line_t          line_o
);

   localparam int OFF_W = $clog2(`PF_LINE_BYTES);

   logic                  busy_q;
   logic                  started_q;
   logic                  discard_q;
   logic [`PF_ADDR_W-1:0] next_addr_q;
   logic [`PF_ADDR_W-1:0] req_addr_q;
   logic                  ack;
   logic                  start;

   // Ack only counts while our cycle is open
   assign ack   = busy_q & wb_rsp_i.ack;
   // New cycle when idle, booted and the queue has room
   assign start = ~busy_q & started_q & free_i & ~redirect_i.valid;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         busy_q      <= 1'b0;
         started_q   <= 1'b0;
         discard_q   <= 1'b0;
         next_addr_q <= '0;
      end else begin
         // Busy from start until the ack cycle, so cyc drops the cycle after
         if (start) begin
            busy_q <= 1'b1;
         end else if (ack) begin
            busy_q <= 1'b0;
         end
         // Redirect wins over the normal line advance
         if (redirect_i.valid) begin
            started_q   <= 1'b1;
            next_addr_q <= {redirect_i.addr[`PF_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
         end else if (ack && !discard_q) begin
            next_addr_q <= next_addr_q + `PF_ADDR_W'(`PF_LINE_BYTES);
         end
         // Redirect during an open cycle marks its data as stale
         if (ack) begin
            discard_q <= 1'b0;
         end else if (redirect_i.valid && busy_q) begin
            discard_q <= 1'b1;
         end
      end
   end

   // Request address frozen for the whole cycle
   always_ff @(posedge clk) begin
      if (start) begin
         req_addr_q <= next_addr_q;
      end
   end

   assign wb_req_o.cyc = busy_q;
   assign wb_req_o.stb = busy_q;
   assign wb_req_o.we  = 1'b0;
   assign wb_req_o.adr = req_addr_q;
   // Whole line every time
   assign wb_req_o.sel = '1;

   // Ack in a redirect cycle belongs to the old stream too
   assign line_push_o = ack & ~discard_q & ~redirect_i.valid;
   assign line_o      = wb_rsp_i.dat;

   // Slave acks only inside an open cycle
   a_ack_in_cycle : assert property (@(posedge clk) disable iff (reset_i)
      wb_rsp_i.ack |-> wb_req_o.cyc);

endmodule

`default_nettype wire

//--- hw/instr_pkg.sv
//********************
// Instruction side types
// Queue window, issued instruction and redirect
//********************
`default_nettype none
`include "prefetch_macros.svh"

package instr_pkg;

   // Bytes starting at the head, byte 0 is the next instruction byte
   typedef struct packed {
      logic [`PF_WINDOW_BYTES-1:0][7:0] bytes;
   } window_t;

   // Issued instruction
   // Bytes at or past len read as zero
   typedef struct packed {
      logic [7:0][7:0] bytes;
      logic [3:0]      len;
      logic            halt;
   } instr_t;

   // Single-cycle restart request to any byte address
   typedef struct packed {
      logic                  valid;
      logic [`PF_ADDR_W-1:0] addr;
   } redirect_t;

endpackage

`default_nettype wire

//--- hw/fetch_pkg.sv
//********************
// Fetch side types
// Wishbone request, response and fetched line
//********************
`default_nettype none
`include "prefetch_macros.svh"

package fetch_pkg;

   // One instruction line, byte 0 at the lowest address
   typedef struct packed {
      logic [`PF_LINE_BYTES-1:0][7:0] bytes;
   } line_t;

   // Master to slave signals of the classic cycle
   typedef struct packed {
      logic                     cyc;
      logic                     stb;
      logic                     we;
      logic [`PF_ADDR_W-1:0]    adr;
      logic [`PF_LINE_BYTES-1:0] sel;
   } wb_req_t;

   // Slave to master signals, read data is a whole line
   typedef struct packed {
      logic  ack;
      line_t dat;
   } wb_rsp_t;

endpackage

`default_nettype wire

//--- include/prefetch_macros.svh
//********************
// Prefetch constants
// Sizes of lines, queue and window, plus the halt opcode
//********************
`ifndef PREFETCH_MACROS_SVH
`define PREFETCH_MACROS_SVH

// Bytes per fetched line and per queue entry
`define PF_LINE_BYTES   16
// Number of queue entries
`define PF_ENTRIES      4
// Bytes visible from the head
`define PF_WINDOW_BYTES 32
// Byte address width
`define PF_ADDR_W       32
// Halt opcode, a one-byte instruction
`define PF_HALT_OP      8'hF4
// Low three bits of the first byte hold length minus one
`define PF_LEN_MASK     8'h07

`endif
